/* build.f */
verilog/datapathPkg.sv
verilog/registerFile.sv
verilog/aluUnit.sv
verilog/controlSequencer.sv
verilog/portArbiter.sv
verilog/apbSlave.sv
verilog/datapathTop.sv
sim/datapathTop_asserts.sv
sim/datapathTb.sv

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module datapathTb -f build.f -o datapathSim

./obj_dir/datapathSim > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
if ! grep -q "Simulation completed successfully" sim.log; then
    exit 1
fi

/* sim/datapathTb.sv */
`timescale 1ns/1ps

module datapathTb;
    import datapathPkg::*;

    localparam int maxWait = 20;                     // cycles before a wait gives up

    logic                    Clock;
    logic                    rst;
    logic [apbAddrWidth-1:0] paddr;
    logic                    psel;
    logic                    penable;
    logic                    pwrite;
    logic [dataWidth-1:0]    pwdata;
    logic [dataWidth-1:0]    prdata;
    logic                    pready;
    logic                    pslverr;

    logic [dataWidth-1:0] shadow [regCount];         // expected register contents
    string                checkNames [$];
    logic [dataWidth-1:0] expectQ [$];
    logic [dataWidth-1:0] actualQ [$];
    int                   errorCount;
    int                   checkCount;
    int                   testStartErrors;
    int                   lastWait;                  // stall cycles of the last transfer
    int                   seedValue;
    logic                 timedOut;

    datapathTop uut (
        .Clock  (Clock),
        .rst    (rst),
        .paddr  (paddr),
        .psel   (psel),
        .penable(penable),
        .pwrite (pwrite),
        .pwdata (pwdata),
        .prdata (prdata),
        .pready (pready),
        .pslverr(pslverr)
    );

    initial begin
        Clock = 1'b0;
        forever #5 Clock = ~Clock;
    end

    function automatic logic [2*dataWidth-1:0] refAlu(input logic [opWidth-1:0] op,
                                                       input logic [dataWidth-1:0] y,
                                                       input logic [dataWidth-1:0] b);
        longint sy;
        longint sb;
        sy = longint'($signed(y));
        sb = longint'($signed(b));
        case (op)
            opAdd: refAlu = {32'h0, y + b};
            opSub: refAlu = {32'h0, y - b};
            opAnd: refAlu = {32'h0, y & b};
            opOr:  refAlu = {32'h0, y | b};
            opShl: refAlu = {32'h0, y << b[4:0]};
            opShr: refAlu = {32'h0, y >> b[4:0]};
            opMul: refAlu = sy * sb;
            opDiv: refAlu = (b == '0) ? {y, {dataWidth{1'b1}}} : {32'(sy % sb), 32'(sy / sb)};
            default: refAlu = '0;
        endcase
    endfunction

    function automatic logic [apbAddrWidth-1:0] regAddr(input int idx);
        regAddr = apbAddrWidth'(int'(regBase) + 4 * idx);
    endfunction

    task automatic checkValue(input string name, input logic [dataWidth-1:0] expected,
                              input logic [dataWidth-1:0] actual);
        checkCount++;
        if (expected !== actual) begin
            errorCount++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // compare side of the testbench, drains whatever the stimulus has queued
    always @(posedge Clock) begin
        while (actualQ.size() > 0) begin
            checkValue(checkNames.pop_front(), expectQ.pop_front(), actualQ.pop_front());
        end
    end

    task automatic queueCheck(input string name, input logic [dataWidth-1:0] expected,
                              input logic [dataWidth-1:0] actual);
        checkNames.push_back(name);
        expectQ.push_back(expected);
        actualQ.push_back(actual);
    endtask

    task automatic busTransfer(input logic [apbAddrWidth-1:0] addr, input logic wr,
                               input logic [dataWidth-1:0] wdata,
                               output logic [dataWidth-1:0] rdata, output logic err);
        rdata    = '0;
        err      = 1'b0;
        lastWait = 0;
        if (!timedOut) begin
            @(negedge Clock);                        // setup cycle
            paddr   = addr;
            pwrite  = wr;
            pwdata  = wdata;
            psel    = 1'b1;
            penable = 1'b0;
            @(negedge Clock);
            penable = 1'b1;
            #1;
            while (!pready && lastWait < maxWait) begin
                @(negedge Clock);
                #1;
                lastWait++;
            end
            if (pready) begin
                rdata = prdata;
                err   = pslverr;
            end else begin
                timedOut = 1'b1;
                $display("Timeout: pready never came for APB address %h", addr);
            end
            @(negedge Clock);                        // transfer ended on the edge before
            psel    = 1'b0;
            penable = 1'b0;
        end
    endtask

    task automatic apbWrite(input logic [apbAddrWidth-1:0] addr,
                            input logic [dataWidth-1:0] data, output logic err);
        logic [dataWidth-1:0] unused;
        busTransfer(addr, 1'b1, data, unused, err);
    endtask

    task automatic apbRead(input logic [apbAddrWidth-1:0] addr,
                           output logic [dataWidth-1:0] data, output logic err);
        busTransfer(addr, 1'b0, '0, data, err);
    endtask

    task automatic waitIdle(output logic [dataWidth-1:0] status);
        logic err;
        int   polls;
        polls = 0;
        apbRead(statusAddr, status, err);
        while (status[busyBit] && polls < maxWait && !timedOut) begin
            apbRead(statusAddr, status, err);
            polls++;
        end
        if (status[busyBit] && !timedOut) begin
            timedOut = 1'b1;
            $display("Timeout: the sequencer never returned to idle");
        end
    endtask

    task automatic compareAll(input string name);
        logic [dataWidth-1:0] data;
        logic                 err;
        for (int i = 0; i < regCount; i++) begin
            apbRead(regAddr(i), data, err);
            queueCheck($sformatf("%s reg %0d", name, i), shadow[i], data);
        end
    endtask

    task automatic runOp(input logic [opWidth-1:0] op, input int srcA, input int srcB,
                         input int dest, input string name);
        logic [dataWidth-1:0]   cmd;
        logic [dataWidth-1:0]   status;
        logic [dataWidth-1:0]   expectStatus;
        logic [2*dataWidth-1:0] expected;
        logic                   err;
        cmd = {16'h0, 4'(dest), 4'(srcB), 4'(srcA), op};
        expectStatus = '0;
        expectStatus[errBit] = 1'b1;                 // illegal opcode unless shown otherwise
        if (op <= opDiv) begin
            expected = refAlu(op, shadow[srcA], shadow[srcB]);
            expectStatus[errBit] = (op == opDiv) && (shadow[srcB] == '0);
            if (op == opMul || op == opDiv) begin
                shadow[loIndex] = expected[dataWidth-1:0];
                shadow[hiIndex] = expected[2*dataWidth-1:dataWidth];
            end else begin
                shadow[dest] = expected[dataWidth-1:0];
            end
        end
        apbWrite(cmdAddr, cmd, err);
        queueCheck({name, " cmd pslverr"}, '0, 32'(err));
        waitIdle(status);
        queueCheck({name, " status"}, expectStatus, status);
        compareAll(name);
    endtask

    task automatic finishTest(input string name);
        int waitCycles;
        waitCycles = 0;
        while (actualQ.size() > 0 && waitCycles < maxWait) begin
            @(negedge Clock);
            waitCycles++;
        end
        if (actualQ.size() > 0) begin
            timedOut = 1'b1;
            $display("Timeout: queued checks of test %s were never compared", name);
        end
        $display("Test %-12s %s, %0d errors", name,
                 (errorCount == testStartErrors) ? "passed" : "FAILED",
                 errorCount - testStartErrors);
        testStartErrors = errorCount;
    endtask

    initial begin
        logic [dataWidth-1:0] data;
        logic [dataWidth-1:0] value;
        logic                 err;
        seedValue       = $urandom(13);
        rst             = 1'b1;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        paddr           = '0;
        pwdata          = '0;
        errorCount      = 0;
        checkCount      = 0;
        testStartErrors = 0;
        timedOut        = 1'b0;
        for (int i = 0; i < regCount; i++) begin
            shadow[i] = '0;
        end
        repeat (3) @(posedge Clock);
        @(negedge Clock);
        rst = 1'b0;

        compareAll("reset");
        apbRead(statusAddr, data, err);
        queueCheck("reset status", '0, data);
        finishTest("reset");

        for (int i = 0; i < regCount; i++) begin
            value = $urandom;
            apbWrite(regAddr(i), value, err);
            queueCheck($sformatf("roundTrip pslverr %0d", i), '0, 32'(err));
            shadow[i] = value;
        end
        compareAll("roundTrip");
        finishTest("roundTrip");

        apbWrite(regAddr(4), 32'd5, err);
        apbWrite(regAddr(5), 32'd6, err);
        shadow[4] = 32'd5;
        shadow[5] = 32'd6;
        runOp(opMul, 4, 5, 0, "mulExample");
        apbRead(regAddr(loIndex), data, err);
        queueCheck("mulExample LO", 32'd30, data);
        apbRead(regAddr(hiIndex), data, err);
        queueCheck("mulExample HI", 32'd0, data);
        for (int n = 0; n < 40; n++) begin
            runOp(opWidth'(n % 8), $urandom_range(15, 0),          // every opcode in turn
                  $urandom_range(15, 0), $urandom_range(15, 0), $sformatf("randomOp %0d", n));
        end
        finishTest("randomOps");

        value = $urandom | 32'h1;                    // nonzero dividend
        apbWrite(regAddr(1), value, err);
        apbWrite(regAddr(2), '0, err);
        shadow[1] = value;
        shadow[2] = '0;
        runOp(opDiv, 1, 2, 3, "divZero");
        apbRead(regAddr(loIndex), data, err);
        queueCheck("divZero LO", 32'hFFFF_FFFF, data);
        apbRead(regAddr(hiIndex), data, err);
        queueCheck("divZero HI", value, data);
        runOp(opWidth'(8 + $urandom_range(7, 0)), 1, 4, 6, "illegalOp");
        finishTest("divErrors");

        // a second command lands while the first add is still in T4
        apbWrite(cmdAddr, {16'h0, 4'd6, 4'd2, 4'd1, opAdd}, err);
        shadow[6] = dataWidth'(refAlu(opAdd, shadow[1], shadow[2]));
        apbWrite(cmdAddr, {16'h0, 4'd7, 4'd1, 4'd1, opSub}, err);
        queueCheck("busyCmd pslverr", 32'd1, 32'(err));
        waitIdle(data);
        compareAll("busyCmd");
        apbWrite(cmdAddr, {16'h0, 4'd0, 4'd1, 4'd4, opMul}, err);
        value = shadow[4];
        {shadow[hiIndex], shadow[loIndex]} = refAlu(opMul, value, shadow[1]);
        apbRead(regAddr(loIndex), data, err);        // stalls until the port is released
        queueCheck("stallRead stalled", 32'd1, 32'(lastWait > 0));
        queueCheck("stallRead LO", shadow[loIndex], data);
        apbRead(statusAddr, data, err);
        queueCheck("stallRead status", '0, data);
        compareAll("stallRead");
        finishTest("contention");

        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0 && !timedOut) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* sim/datapathTop_asserts.sv */
`timescale 1ns/1ps

module datapathTop_asserts (
    input logic                                 Clock,
    input logic                                 rst,
    input logic                                 psel,
    input logic                                 penable,
    input logic                                 pready,
    input logic                                 apbReq,
    input logic [datapathPkg::regAddrWidth-1:0] apbAddr,
    input logic                                 apbGrant,
    input logic                                 cmdStart,
    input logic                                 busy
);

    int busyCycles;                                  // busy samples seen so far in a row

    always_ff @(posedge Clock) begin
        if (rst || !busy) begin
            busyCycles <= 0;
        end else begin
            busyCycles <= busyCycles + 1;
        end
    end

    // a stalled register request stays on the port until it is granted
    requestHeld: assert property (@(posedge Clock) disable iff (rst)
                                  (apbReq && !apbGrant) |=> (apbReq && $stable(apbAddr)))
        else $error("APB register request dropped or changed before its grant");

    busyLength: assert property (@(posedge Clock) disable iff (rst) busy |-> busyCycles < 4)
        else $error("busy stayed high for more than four cycles");

    idleNoWait: assert property (@(posedge Clock) disable iff (rst)
                                 (psel && !penable && !busy && !cmdStart) |=> pready)
        else $error("APB access started while idle did not end in its first access cycle");

endmodule

bind datapathTop datapathTop_asserts asserts (
    .Clock   (Clock),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .pready  (pready),
    .apbReq  (apbReq),
    .apbAddr (apbAddr),
    .apbGrant(apbGrant),
    .cmdStart(cmdStart),
    .busy    (busy)
);

/* verilog/aluUnit.sv */
`timescale 1ns/1ps

module aluUnit (
    input  logic [datapathPkg::opWidth-1:0]       opcode,
    input  logic [datapathPkg::dataWidth-1:0]     operandY,
    input  logic [datapathPkg::dataWidth-1:0]     operandBus,
    output logic [2*datapathPkg::dataWidth-1:0]   result,
    output logic                                  divZero
);
    import datapathPkg::*;

    logic signed [2*dataWidth-1:0] wideY;
    logic signed [2*dataWidth-1:0] wideBus;
    logic signed [2*dataWidth-1:0] safeDivisor;
    logic signed [2*dataWidth-1:0] product;
    logic signed [2*dataWidth-1:0] quotient;
    logic signed [2*dataWidth-1:0] remainder;
    logic        [shiftWidth-1:0]  shiftAmount;
    logic                          busZero;

    assign wideY   = {{dataWidth{operandY[dataWidth-1]}}, operandY};     // sign extend
    assign wideBus = {{dataWidth{operandBus[dataWidth-1]}}, operandBus};

    assign shiftAmount = operandBus[shiftWidth-1:0];   // low 5 bits only

    // 64-bit divide keeps the most negative value over -1 well defined
    assign busZero     = (operandBus == '0);
    assign safeDivisor = busZero ? 64'sd1 : wideBus;
    assign product     = wideY * wideBus;
    assign quotient    = wideY / safeDivisor;
    assign remainder   = wideY % safeDivisor;

    assign divZero = (opcode == opDiv) && busZero;

    always_comb begin
        result = '0;                                   // upper half zero unless mul/div
        case (opcode)
            opAdd: result[dataWidth-1:0] = operandY + operandBus;
            opSub: result[dataWidth-1:0] = operandY - operandBus;
            opAnd: result[dataWidth-1:0] = operandY & operandBus;
            opOr:  result[dataWidth-1:0] = operandY | operandBus;
            opShl: result[dataWidth-1:0] = operandY << shiftAmount;
            opShr: result[dataWidth-1:0] = operandY >> shiftAmount;    // logical shift
            opMul: result = product;
            opDiv: begin
                if (busZero) begin
                    result = {operandY, divZeroQuot};  // remainder keeps the dividend
                end else begin
                    result = {remainder[dataWidth-1:0], quotient[dataWidth-1:0]};
                end
            end
            default: result = '0;
        endcase
    end

endmodule

/* verilog/apbSlave.sv */
`timescale 1ns/1ps

module apbSlave (
    input  logic                                 Clock,
    input  logic                                 rst,
    input  logic [datapathPkg::apbAddrWidth-1:0] paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [datapathPkg::dataWidth-1:0]    pwdata,
    input  logic                                 apbGrant,
    input  logic [datapathPkg::dataWidth-1:0]    apbRdata,
    input  logic                                 busy,
    input  logic                                 opError,
    output logic [datapathPkg::dataWidth-1:0]    prdata,
    output logic                                 pready,
    output logic                                 pslverr,
    output logic                                 apbReq,
    output logic [datapathPkg::regAddrWidth-1:0] apbAddr,
    output logic                                 apbWrite,
    output logic [datapathPkg::dataWidth-1:0]    apbWdata,
    output logic                                 cmdStart,
    output logic [datapathPkg::dataWidth-1:0]    cmdWord
);
    import datapathPkg::*;

    logic                    access;
    logic [apbAddrWidth-1:0] regOffset;
    logic                    regHit;
    logic                    cmdHit;
    logic                    statusHit;
    logic                    badAddr;
    logic                    cmdBlocked;
    logic                    cmdAccept;

    assign access    = psel && penable;
    assign regOffset = paddr - regBase;                    // wraps high below the base
    assign regHit    = (regOffset[1:0] == 2'b00) && (regOffset[apbAddrWidth-1:2] < regCount);
    assign cmdHit    = (paddr == cmdAddr);
    assign statusHit = (paddr == statusAddr);
    assign badAddr   = !(regHit || cmdHit || statusHit);

    assign cmdBlocked = busy || cmdStart;                  // pending start counts as busy
    assign cmdAccept  = access && cmdHit && pwrite && !cmdBlocked;

    // register accesses go through the shared port and wait for it
    assign apbReq   = access && regHit;
    assign apbAddr  = regOffset[regAddrWidth+1:2];
    assign apbWrite = pwrite;
    assign apbWdata = pwdata;

    assign pready  = access && (!regHit || apbGrant);
    assign pslverr = pready && (badAddr || (cmdHit && pwrite && cmdBlocked));

    always_comb begin
        prdata = '0;                                       // also for bad addresses
        if (regHit) begin
            prdata = apbRdata;
        end else if (statusHit) begin
            prdata[busyBit] = cmdBlocked;
            prdata[errBit]  = opError;
        end
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            cmdStart <= 1'b0;
        end else begin
            cmdStart <= cmdAccept;                         // one cycle pulse
        end
    end

    always_ff @(posedge Clock) begin
        if (cmdAccept) begin
            cmdWord <= pwdata;
        end
    end

endmodule

/* verilog/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer (
    input  logic                                 Clock,
    input  logic                                 rst,
    input  logic                                 cmdStart,
    input  logic [datapathPkg::dataWidth-1:0]    cmdWord,
    input  logic                                 seqGrant,
    input  logic [datapathPkg::dataWidth-1:0]    seqRdata,
    output logic                                 seqReq,
    output logic [datapathPkg::regAddrWidth-1:0] seqAddr,
    output logic                                 seqWrite,
    output logic [datapathPkg::dataWidth-1:0]    seqWdata,
    output logic                                 busy,
    output logic                                 opError
);
    import datapathPkg::*;

    typedef enum logic [2:0] {sIdle, sT3, sT4, sT5, sT6, sErr} stateT;

    stateT                  state;
    logic [opWidth-1:0]     opReg;
    logic [fieldWidth-1:0]  srcA;
    logic [fieldWidth-1:0]  srcB;
    logic [fieldWidth-1:0]  dest;
    logic [dataWidth-1:0]   yReg;
    logic [2*dataWidth-1:0] zReg;
    logic [2*dataWidth-1:0] aluResult;
    logic                   aluDivZero;
    logic                   wideOp;
    logic                   opLegal;
    logic                   accept;

    assign wideOp  = (opReg == opMul) || (opReg == opDiv);        // these also write HI
    assign opLegal = (cmdWord[cmdOpLsb +: opWidth] <= opDiv);
    assign accept  = cmdStart && (state == sIdle);
    assign busy    = (state != sIdle);

    aluUnit alu (
        .opcode    (opReg),
        .operandY  (yReg),
        .operandBus(seqRdata),            // source B comes straight off the port in T4
        .result    (aluResult),
        .divZero   (aluDivZero)
    );

    always_comb begin
        seqReq   = 1'b0;
        seqAddr  = '0;
        seqWrite = 1'b0;
        seqWdata = '0;
        case (state)
            sT3: begin
                seqReq  = 1'b1;
                seqAddr = regAddrWidth'(srcA);
            end
            sT4: begin
                seqReq  = 1'b1;
                seqAddr = regAddrWidth'(srcB);
            end
            sT5: begin
                seqReq   = 1'b1;
                seqWrite = 1'b1;
                seqAddr  = wideOp ? loIndex : regAddrWidth'(dest);
                seqWdata = zReg[dataWidth-1:0];                    // Zlow
            end
            sT6: begin
                seqReq   = 1'b1;
                seqWrite = 1'b1;
                seqAddr  = hiIndex;
                seqWdata = zReg[2*dataWidth-1:dataWidth];          // Zhigh
            end
            default: ;
        endcase
    end

    always_ff @(posedge Clock) begin
        if (rst) begin
            state   <= sIdle;
            opError <= 1'b0;
        end else begin
            case (state)
                sIdle: begin
                    if (cmdStart) begin
                        opError <= !opLegal;             // cleared by every new command
                        state   <= opLegal ? sT3 : sErr;
                    end
                end
                sT3: if (seqGrant) state <= sT4;
                sT4: begin
                    if (seqGrant) begin
                        opError <= aluDivZero;
                        state   <= sT5;
                    end
                end
                sT5: if (seqGrant) state <= wideOp ? sT6 : sIdle;
                sT6: if (seqGrant) state <= sIdle;
                default: state <= sIdle;                  // sErr holds busy one cycle
            endcase
        end
    end

    always_ff @(posedge Clock) begin
        if (accept) begin
            opReg <= cmdWord[cmdOpLsb +: opWidth];
            srcA  <= cmdWord[cmdSrcALsb +: fieldWidth];
            srcB  <= cmdWord[cmdSrcBLsb +: fieldWidth];
            dest  <= cmdWord[cmdDestLsb +: fieldWidth];
        end
        if (state == sT3 && seqGrant) begin
            yReg <= seqRdata;
        end
        if (state == sT4 && seqGrant) begin
            zReg <= aluResult;
        end
    end

endmodule

/* verilog/datapathPkg.sv */
package datapathPkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;
    localparam int regCount     = 18;                 // R0..R15, HI, LO
    localparam int apbAddrWidth = 8;
    localparam int opWidth      = 4;
    localparam int fieldWidth   = 4;                  // register field in the command word
    localparam int shiftWidth   = $clog2(dataWidth);

    localparam logic [regAddrWidth-1:0] hiIndex = 5'd16;
    localparam logic [regAddrWidth-1:0] loIndex = 5'd17;

    localparam logic [opWidth-1:0] opAdd = 4'd0;
    localparam logic [opWidth-1:0] opSub = 4'd1;
    localparam logic [opWidth-1:0] opAnd = 4'd2;
    localparam logic [opWidth-1:0] opOr  = 4'd3;
    localparam logic [opWidth-1:0] opShl = 4'd4;
    localparam logic [opWidth-1:0] opShr = 4'd5;
    localparam logic [opWidth-1:0] opMul = 4'd6;
    localparam logic [opWidth-1:0] opDiv = 4'd7;      // highest legal opcode

    localparam logic [apbAddrWidth-1:0] regBase    = 8'h00;
    localparam logic [apbAddrWidth-1:0] cmdAddr    = 8'h80;
    localparam logic [apbAddrWidth-1:0] statusAddr = 8'h84;

    localparam int cmdOpLsb   = 0;
    localparam int cmdSrcALsb = 4;
    localparam int cmdSrcBLsb = 8;
    localparam int cmdDestLsb = 12;

    localparam int busyBit = 0;
    localparam int errBit  = 1;

    localparam logic [dataWidth-1:0] divZeroQuot = '1;

endpackage

/* verilog/datapathTop.sv */
`timescale 1ns/1ps

module datapathTop (
    input  logic                                 Clock,
    input  logic                                 rst,
    input  logic [datapathPkg::apbAddrWidth-1:0] paddr,
    input  logic                                 psel,
    input  logic                                 penable,
    input  logic                                 pwrite,
    input  logic [datapathPkg::dataWidth-1:0]    pwdata,
    output logic [datapathPkg::dataWidth-1:0]    prdata,
    output logic                                 pready,
    output logic                                 pslverr
);
    import datapathPkg::*;

    logic                    apbReq;
    logic [regAddrWidth-1:0] apbAddr;
    logic                    apbWrite;
    logic [dataWidth-1:0]    apbWdata;
    logic                    apbGrant;
    logic [dataWidth-1:0]    apbRdata;
    logic                    seqReq;
    logic [regAddrWidth-1:0] seqAddr;
    logic                    seqWrite;
    logic [dataWidth-1:0]    seqWdata;
    logic                    seqGrant;
    logic [dataWidth-1:0]    seqRdata;
    logic [regAddrWidth-1:0] portAddr;
    logic                    portWrite;
    logic [dataWidth-1:0]    portWdata;
    logic [dataWidth-1:0]    portRdata;
    logic                    cmdStart;
    logic [dataWidth-1:0]    cmdWord;
    logic                    busy;
    logic                    opError;

    apbSlave apb (
        .Clock   (Clock),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .apbGrant(apbGrant),
        .apbRdata(apbRdata),
        .busy    (busy),
        .opError (opError),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .apbReq  (apbReq),
        .apbAddr (apbAddr),
        .apbWrite(apbWrite),
        .apbWdata(apbWdata),
        .cmdStart(cmdStart),
        .cmdWord (cmdWord)
    );

    portArbiter arb (
        .seqReq   (seqReq),
        .seqAddr  (seqAddr),
        .seqWrite (seqWrite),
        .seqWdata (seqWdata),
        .apbReq   (apbReq),
        .apbAddr  (apbAddr),
        .apbWrite (apbWrite),
        .apbWdata (apbWdata),
        .portRdata(portRdata),
        .seqGrant (seqGrant),
        .apbGrant (apbGrant),
        .portAddr (portAddr),
        .portWrite(portWrite),
        .portWdata(portWdata),
        .seqRdata (seqRdata),
        .apbRdata (apbRdata)
    );

    registerFile regFile (
        .Clock    (Clock),
        .rst      (rst),
        .portAddr (portAddr),
        .portWrite(portWrite),
        .portWdata(portWdata),
        .portRdata(portRdata)
    );

    controlSequencer seq (
        .Clock   (Clock),
        .rst     (rst),
        .cmdStart(cmdStart),
        .cmdWord (cmdWord),
        .seqGrant(seqGrant),
        .seqRdata(seqRdata),
        .seqReq  (seqReq),
        .seqAddr (seqAddr),
        .seqWrite(seqWrite),
        .seqWdata(seqWdata),
        .busy    (busy),
        .opError (opError)
    );

endmodule

/* verilog/portArbiter.sv */
`timescale 1ns/1ps

module portArbiter (
    input  logic                                 seqReq,
    input  logic [datapathPkg::regAddrWidth-1:0] seqAddr,
    input  logic                                 seqWrite,
    input  logic [datapathPkg::dataWidth-1:0]    seqWdata,
    input  logic                                 apbReq,
    input  logic [datapathPkg::regAddrWidth-1:0] apbAddr,
    input  logic                                 apbWrite,
    input  logic [datapathPkg::dataWidth-1:0]    apbWdata,
    input  logic [datapathPkg::dataWidth-1:0]    portRdata,
    output logic                                 seqGrant,
    output logic                                 apbGrant,
    output logic [datapathPkg::regAddrWidth-1:0] portAddr,
    output logic                                 portWrite,
    output logic [datapathPkg::dataWidth-1:0]    portWdata,
    output logic [datapathPkg::dataWidth-1:0]    seqRdata,
    output logic [datapathPkg::dataWidth-1:0]    apbRdata
);

    // fixed priority, sequencer first
    assign seqGrant = seqReq;
    assign apbGrant = apbReq && !seqReq;

    assign portAddr  = seqGrant ? seqAddr : apbAddr;
    assign portWdata = seqGrant ? seqWdata : apbWdata;
    assign portWrite = (seqGrant && seqWrite) || (apbGrant && apbWrite);   // losing write dropped

    assign seqRdata = seqGrant ? portRdata : '0;
    assign apbRdata = apbGrant ? portRdata : '0;

endmodule

/* verilog/registerFile.sv */
`timescale 1ns/1ps

module registerFile (
    input  logic                                 Clock,
    input  logic                                 rst,
    input  logic [datapathPkg::regAddrWidth-1:0] portAddr,
    input  logic                                 portWrite,
    input  logic [datapathPkg::dataWidth-1:0]    portWdata,
    output logic [datapathPkg::dataWidth-1:0]    portRdata
);
    import datapathPkg::*;

    logic [dataWidth-1:0] regs [regCount];   // R0..R15 then HI, LO
    logic                 addrValid;

    assign addrValid = (portAddr < regAddrWidth'(regCount));
    assign portRdata = addrValid ? regs[portAddr] : '0;   // unmapped slots read zero

    always_ff @(posedge Clock) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (portWrite && addrValid) begin
            regs[portAddr] <= portWdata;
        end
    end

endmodule
